// File: include/resp_route_macros.svh
// Sizing constants for the response router and its FIFO
`ifndef RESP_ROUTE_MACROS_SVH
`define RESP_ROUTE_MACROS_SVH

// ----------------------------------------
// Requestor side
// ----------------------------------------

// Number of requestor ports, also the width of every route mask
`define RESP_NUM_REQUESTORS 4

// Width of one response data word
`define RESP_DATA_WIDTH 32

// ----------------------------------------
// Response FIFO
// ----------------------------------------

// Entries in the response FIFO, kept a power of two
`define RESP_FIFO_DEPTH 16

// Fill level that raises programmable-full
`define RESP_FIFO_PROG_THRESH 8

// Cycles the FIFO reports busy once reset is released
`define RESP_FIFO_SETTLE_CYCLES 4

`endif

// File: logic/resp_route_pkg.sv
// Shared types for the response fan-out router
`include "resp_route_macros.svh"

package resp_route_pkg;

  // ----------------------------------------
  // Payload and routing vectors
  // ----------------------------------------

  // One response data word
  typedef logic [`RESP_DATA_WIDTH-1:0] resp_data_t;

  // One-hot or multi-hot requestor set
  typedef logic [`RESP_NUM_REQUESTORS-1:0] requestor_mask_t;

  // FIFO occupancy, wide enough to hold the full depth
  typedef logic [$clog2(`RESP_FIFO_DEPTH):0] fifo_count_t;

  // ----------------------------------------
  // Route level decode
  // ----------------------------------------

  // Hierarchy level the router decodes, code 3 is reserved
  typedef enum logic [1:0] {
    level_cu     = 2'd0,
    level_bundle = 2'd1,
    level_lane   = 2'd2
  } route_level_e;

endpackage : resp_route_pkg

// File: logic/resp_sync_fifo.sv
// Synchronous first-word-fall-through FIFO with fill flags and a reset settle window
`include "resp_route_macros.svh"

module resp_sync_fifo import resp_route_pkg::*; #(
  parameter int          width         = $bits(resp_data_t) + 3 * `RESP_NUM_REQUESTORS,
  parameter int          depth         = `RESP_FIFO_DEPTH,
  parameter fifo_count_t prog_thresh   = `RESP_FIFO_PROG_THRESH,
  parameter int          settle_cycles = `RESP_FIFO_SETTLE_CYCLES
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [width-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [width-1:0] dout,
  output logic             empty,
  output logic             full,
  output logic             prog_full,
  output logic             busy
);

  localparam int ptr_w    = $clog2(depth);
  localparam int cnt_w    = ptr_w + 1;
  localparam int settle_w = $clog2(settle_cycles + 1);

  logic [width-1:0]    mem [depth];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [cnt_w-1:0]    count;
  logic [settle_w-1:0] settle_cnt;
  logic                do_wr;
  logic                do_rd;

  // ----------------------------------------
  // Accepted operations
  // ----------------------------------------
  // Nothing moves while settling, a write into a full FIFO is dropped
  assign do_wr = wr_en & ~full & ~busy;
  assign do_rd = rd_en & ~empty & ~busy;

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word shows up without a read
  assign dout = mem[rd_ptr];

  // ----------------------------------------
  // Flags and settle counter
  // ----------------------------------------
  assign empty     = (count == '0);
  assign full      = (count == cnt_w'(depth));
  assign prog_full = (count >= cnt_w'(prog_thresh));

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      settle_cnt <= settle_w'(settle_cycles);
    end else if (settle_cnt != '0) begin
      settle_cnt <= settle_cnt - 1'b1;
    end
  end

  assign busy = (settle_cnt != '0);

endmodule : resp_sync_fifo

// File: logic/demux_bus_one_hot.sv
// Registered one-hot demux that copies a data word to every selected port
module demux_bus_one_hot import resp_route_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset_control,
  input  requestor_mask_t sel_in,
  input  logic            data_in_valid,
  input  resp_data_t      data_in,
  output resp_data_t      data_out,
  output requestor_mask_t data_out_valid
);

  // ----------------------------------------
  // Per-port valid
  // ----------------------------------------
  // Several ports may fire together on a multi-hot select
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      data_out_valid <= '0;
    end else if (data_in_valid) begin
      data_out_valid <= sel_in;
    end else begin
      data_out_valid <= '0;
    end
  end

  // ----------------------------------------
  // Shared data word
  // ----------------------------------------
  // Held between transfers
  always_ff @(posedge ap_clk) begin
    if (data_in_valid) begin
      data_out <= data_in;
    end
  end

endmodule : demux_bus_one_hot

// File: logic/route_level_config.sv
// Run-time register for the router decode level, rejecting the reserved code
module route_level_config import resp_route_pkg::*; (
  input  logic         ap_clk,
  input  logic         areset_control,
  input  logic         cfg_wr,
  input  logic [1:0]   cfg_level,
  output route_level_e route_level,
  output logic         cfg_error
);

  logic level_legal;

  // ----------------------------------------
  // Code check
  // ----------------------------------------
  always_comb begin
    case (cfg_level)
      level_cu,
      level_bundle,
      level_lane: level_legal = 1'b1;
      default:    level_legal = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Level register and error pulse
  // ----------------------------------------
  // Error lasts one cycle per rejected write
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      route_level <= level_cu;
      cfg_error   <= 1'b0;
    end else if (cfg_wr) begin
      if (level_legal) begin
        route_level <= route_level_e'(cfg_level);
        cfg_error   <= 1'b0;
      end else begin
        cfg_error <= 1'b1;
      end
    end else begin
      cfg_error <= 1'b0;
    end
  end

endmodule : route_level_config

// File: logic/response_arbiter_1_to_n.sv
// Response router that buffers tagged responses and fans them out by requestor mask
`include "resp_route_macros.svh"

module response_arbiter_1_to_n import resp_route_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset_control,
  input  route_level_e    route_level,
  input  logic            response_in_valid,
  input  resp_data_t      response_in_data,
  input  requestor_mask_t from_cu,
  input  requestor_mask_t from_bundle,
  input  requestor_mask_t from_lane,
  input  requestor_mask_t requestor_ready,
  output requestor_mask_t response_out_valid,
  output resp_data_t      response_out_data,
  output logic            fifo_full,
  output logic            fifo_prog_full,
  output logic            fifo_setup
);

  localparam int data_w = $bits(resp_data_t);
  localparam int mask_w = $bits(requestor_mask_t);
  localparam int fifo_w = data_w + 3 * mask_w;

  // Input stage
  logic            in_valid_reg;
  resp_data_t      in_data_reg;
  requestor_mask_t in_cu_reg;
  requestor_mask_t in_bundle_reg;
  requestor_mask_t in_lane_reg;

  // FIFO side
  logic [fifo_w-1:0] fifo_din;
  logic [fifo_w-1:0] fifo_dout;
  logic              fifo_empty;
  logic              fifo_busy;
  logic              fifo_pop;

  // Head fields
  resp_data_t      head_data;
  requestor_mask_t head_cu;
  requestor_mask_t head_bundle;
  requestor_mask_t head_lane;
  requestor_mask_t head_mask;

  // Demux stage
  logic            demux_in_valid;
  requestor_mask_t demux_in_sel;
  resp_data_t      demux_in_data;
  resp_data_t      demux_out_data;
  requestor_mask_t demux_out_valid;

  // ----------------------------------------
  // Input register
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
    end else begin
      in_valid_reg <= response_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_data_reg   <= response_in_data;
    in_cu_reg     <= from_cu;
    in_bundle_reg <= from_bundle;
    in_lane_reg   <= from_lane;
  end

  // ----------------------------------------
  // Response FIFO
  // ----------------------------------------
  assign fifo_din = {in_lane_reg, in_bundle_reg, in_cu_reg, in_data_reg};

  resp_sync_fifo #(
    .depth(`RESP_FIFO_DEPTH)
  ) inst_resp_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (fifo_din),
    .wr_en         (in_valid_reg),
    .rd_en         (fifo_pop),
    .dout          (fifo_dout),
    .empty         (fifo_empty),
    .full          (fifo_full),
    .prog_full     (fifo_prog_full),
    .busy          (fifo_busy)
  );

  assign head_data   = fifo_dout[data_w-1:0];
  assign head_cu     = fifo_dout[data_w +: mask_w];
  assign head_bundle = fifo_dout[data_w + mask_w +: mask_w];
  assign head_lane   = fifo_dout[data_w + 2 * mask_w +: mask_w];

  // Pick the mask for the active hierarchy level
  always_comb begin
    case (route_level)
      level_bundle: head_mask = head_bundle;
      level_lane:   head_mask = head_lane;
      default:      head_mask = head_cu;
    endcase
  end

  // Pop once every addressed requestor is ready; an empty mask is dropped
  assign fifo_pop = ~fifo_empty & ((requestor_ready & head_mask) == head_mask);

  // ----------------------------------------
  // Demux input register and demux
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      demux_in_valid <= 1'b0;
    end else begin
      demux_in_valid <= fifo_pop & (|head_mask);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (fifo_pop) begin
      demux_in_sel  <= head_mask;
      demux_in_data <= head_data;
    end
  end

  demux_bus_one_hot inst_demux_bus (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .sel_in        (demux_in_sel),
    .data_in_valid (demux_in_valid),
    .data_in       (demux_in_data),
    .data_out      (demux_out_data),
    .data_out_valid(demux_out_valid)
  );

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_out_valid <= '0;
      fifo_setup         <= 1'b1;
    end else begin
      response_out_valid <= demux_out_valid;
      fifo_setup         <= fifo_busy;
    end
  end

  always_ff @(posedge ap_clk) begin
    response_out_data <= demux_out_data;
  end

endmodule : response_arbiter_1_to_n

// File: logic/resp_route_top.sv
// Top of the response fan-out stage with its route level register
module resp_route_top import resp_route_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset_control,
  input  logic            response_in_valid,
  input  resp_data_t      response_in_data,
  input  requestor_mask_t from_cu,
  input  requestor_mask_t from_bundle,
  input  requestor_mask_t from_lane,
  input  requestor_mask_t requestor_ready,
  input  logic            cfg_wr,
  input  logic [1:0]      cfg_level,
  output requestor_mask_t response_out_valid,
  output resp_data_t      response_out_data,
  output logic            fifo_full,
  output logic            fifo_prog_full,
  output logic            fifo_setup,
  output route_level_e    route_level,
  output logic            cfg_error
);

  // ----------------------------------------
  // Level configuration
  // ----------------------------------------
  route_level_config inst_route_level_config (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .cfg_wr        (cfg_wr),
    .cfg_level     (cfg_level),
    .route_level   (route_level),
    .cfg_error     (cfg_error)
  );

  // ----------------------------------------
  // Router
  // ----------------------------------------
  response_arbiter_1_to_n inst_response_arbiter (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .route_level       (route_level),
    .response_in_valid (response_in_valid),
    .response_in_data  (response_in_data),
    .from_cu           (from_cu),
    .from_bundle       (from_bundle),
    .from_lane         (from_lane),
    .requestor_ready   (requestor_ready),
    .response_out_valid(response_out_valid),
    .response_out_data (response_out_data),
    .fifo_full         (fifo_full),
    .fifo_prog_full    (fifo_prog_full),
    .fifo_setup        (fifo_setup)
  );

endmodule : resp_route_top

// File: tb/resp_route_tb.sv
// Table-driven testbench for the response fan-out stage with per-requestor scoreboards
`include "resp_route_macros.svh"

module resp_route_tb import resp_route_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries    = 19;
  localparam int burst_len      = `RESP_FIFO_DEPTH;
  localparam int timeout_cycles = (num_entries + burst_len) * 40 + 16 + `RESP_FIFO_SETTLE_CYCLES;

  typedef struct packed {
    route_level_e    level;
    resp_data_t      data;
    requestor_mask_t cu;
    requestor_mask_t bundle;
    requestor_mask_t lane;
    logic            stall;
  } entry_t;

  logic            ap_clk;
  logic            areset_control;
  logic            response_in_valid;
  resp_data_t      response_in_data;
  requestor_mask_t from_cu;
  requestor_mask_t from_bundle;
  requestor_mask_t from_lane;
  requestor_mask_t requestor_ready;
  logic            cfg_wr;
  logic [1:0]      cfg_level;
  requestor_mask_t response_out_valid;
  resp_data_t      response_out_data;
  logic            fifo_full;
  logic            fifo_prog_full;
  logic            fifo_setup;
  route_level_e    route_level;
  logic            cfg_error;

  integer       seed = 32'hdd1f;
  int           cycle_count = 0;
  int           fill_idx = 0;
  logic         stall_mode = 1'b0;
  logic         hold_ready = 1'b0;
  route_level_e cur_level = level_cu;
  entry_t       stim_table [num_entries];
  resp_data_t   exp_q [`RESP_NUM_REQUESTORS][$];

  resp_route_top dut_i (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .response_in_valid (response_in_valid),
    .response_in_data  (response_in_data),
    .from_cu           (from_cu),
    .from_bundle       (from_bundle),
    .from_lane         (from_lane),
    .requestor_ready   (requestor_ready),
    .cfg_wr            (cfg_wr),
    .cfg_level         (cfg_level),
    .response_out_valid(response_out_valid),
    .response_out_data (response_out_data),
    .fifo_full         (fifo_full),
    .fifo_prog_full    (fifo_prog_full),
    .fifo_setup        (fifo_setup),
    .route_level       (route_level),
    .cfg_error         (cfg_error)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic add_entry(input route_level_e lvl, input requestor_mask_t cu,
                           input requestor_mask_t bundle, input requestor_mask_t lane,
                           input logic stall);
    stim_table[fill_idx] = '{lvl, resp_data_t'($random(seed)), cu, bundle, lane, stall};
    fill_idx++;
  endtask

  // Mask that the router decodes at the entry's level
  function automatic requestor_mask_t mask_at_level(input entry_t e);
    case (e.level)
      level_bundle: return e.bundle;
      level_lane:   return e.lane;
      default:      return e.cu;
    endcase
  endfunction

  function automatic bit queues_empty();
    for (int r = 0; r < `RESP_NUM_REQUESTORS; r++) begin
      if (exp_q[r].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Drives one response at the current falling edge and books the expected data
  task automatic send_response(input entry_t e);
    requestor_mask_t m;
    m = mask_at_level(e);
    response_in_valid = 1'b1;
    response_in_data  = e.data;
    from_cu           = e.cu;
    from_bundle       = e.bundle;
    from_lane         = e.lane;
    for (int r = 0; r < `RESP_NUM_REQUESTORS; r++) begin
      if (m[r]) begin
        exp_q[r].push_back(e.data);
      end
    end
  endtask

  // Also flushes zero-mask heads left behind the last delivered word
  task automatic drain_router();
    stall_mode <= 1'b0;
    hold_ready <= 1'b0;
    while (!queues_empty()) begin
      @(posedge ap_clk);
    end
    repeat (8) @(negedge ap_clk);
  endtask

  task automatic write_level(input route_level_e lvl);
    cfg_wr    = 1'b1;
    cfg_level = lvl;
    cur_level = lvl;
    @(negedge ap_clk);
    cfg_wr = 1'b0;
    assert (route_level == lvl) else
      fail_run($sformatf("[ERROR] route_level: got %h, expected %h", route_level, lvl));
    assert (cfg_error == 1'b0) else
      fail_run($sformatf("[ERROR] cfg_error: got %h, expected %h", cfg_error, 1'b0));
  endtask

  task automatic check_reserved_level();
    cfg_wr    = 1'b1;
    cfg_level = 2'd3;
    @(negedge ap_clk);
    cfg_wr = 1'b0;
    assert (cfg_error == 1'b1) else
      fail_run($sformatf("[ERROR] cfg_error: got %h, expected %h", cfg_error, 1'b1));
    assert (route_level == cur_level) else
      fail_run($sformatf("[ERROR] route_level: got %h, expected %h", route_level, cur_level));
    @(negedge ap_clk);
    assert (cfg_error == 1'b0) else
      fail_run($sformatf("[ERROR] cfg_error: got %h, expected %h", cfg_error, 1'b0));
  endtask

  // ----------------------------------------
  // Ready pattern, scoreboard and watchdog
  // ----------------------------------------
  always @(negedge ap_clk) begin
    if (hold_ready) begin
      requestor_ready <= '0;
    end else if (stall_mode) begin
      requestor_ready <= requestor_mask_t'($random(seed));
    end else begin
      requestor_ready <= '1;
    end
  end

  always @(negedge ap_clk) begin
    resp_data_t expected;
    if (!areset_control) begin
      for (int r = 0; r < `RESP_NUM_REQUESTORS; r++) begin
        if (response_out_valid[r]) begin
          assert (exp_q[r].size() != 0) else
            fail_run($sformatf("Requestor %0d got a response that was never sent to it", r));
          expected = exp_q[r].pop_front();
          assert (response_out_data == expected) else
            fail_run($sformatf("[ERROR] response_out_data (requestor %0d): got %h, expected %h",
                               r, response_out_data, expected));
        end
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("Run did not finish within %0d cycles", timeout_cycles));
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    entry_t          burst_entry;
    requestor_mask_t m;
    areset_control    = 1'b1;
    response_in_valid = 1'b0;
    response_in_data  = '0;
    from_cu           = '0;
    from_bundle       = '0;
    from_lane         = '0;
    requestor_ready   = '1;
    cfg_wr            = 1'b0;
    cfg_level         = 2'd0;

    // Unicast at each level while the other levels' masks point elsewhere
    add_entry(level_cu,     4'b0001, 4'b0010, 4'b0100, 1'b0);
    add_entry(level_cu,     4'b1000, 4'b0001, 4'b0010, 1'b0);
    add_entry(level_bundle, 4'b0001, 4'b0100, 4'b1000, 1'b0);
    add_entry(level_bundle, 4'b0010, 4'b1000, 4'b0001, 1'b0);
    add_entry(level_lane,   4'b0100, 4'b0001, 4'b0010, 1'b0);
    add_entry(level_lane,   4'b0001, 4'b0010, 4'b1000, 1'b0);
    // Multi-hot and zero masks
    add_entry(level_lane,   4'b0000, 4'b0000, 4'b1011, 1'b0);
    add_entry(level_lane,   4'b1111, 4'b1111, 4'b0000, 1'b0);
    add_entry(level_cu,     4'b1111, 4'b0000, 4'b0000, 1'b0);
    add_entry(level_cu,     4'b0000, 4'b1111, 4'b1111, 1'b0);
    add_entry(level_cu,     4'b0110, 4'b0001, 4'b0001, 1'b0);
    // Random ready stalls
    add_entry(level_bundle, 4'b0100, 4'b0001, 4'b0010, 1'b1);
    add_entry(level_bundle, 4'b0010, 4'b0011, 4'b0001, 1'b1);
    add_entry(level_bundle, 4'b0001, 4'b1000, 4'b0100, 1'b1);
    add_entry(level_bundle, 4'b1000, 4'b0110, 4'b0010, 1'b1);
    add_entry(level_bundle, 4'b0011, 4'b1111, 4'b1000, 1'b1);
    add_entry(level_bundle, 4'b1100, 4'b0000, 4'b0001, 1'b1);
    add_entry(level_bundle, 4'b0001, 4'b0100, 4'b0110, 1'b1);
    add_entry(level_bundle, 4'b0010, 4'b1001, 4'b0100, 1'b1);

    repeat (16) @(negedge ap_clk);
    areset_control = 1'b0;
    @(negedge ap_clk);
    assert (fifo_setup == 1'b1) else
      fail_run($sformatf("[ERROR] fifo_setup: got %h, expected %h", fifo_setup, 1'b1));
    assert (route_level == level_cu) else
      fail_run($sformatf("[ERROR] route_level: got %h, expected %h", route_level, level_cu));
    assert (response_out_valid == '0) else
      fail_run($sformatf("[ERROR] response_out_valid: got %h, expected %h",
                         response_out_valid, requestor_mask_t'(0)));
    assert (fifo_full == 1'b0) else
      fail_run($sformatf("[ERROR] fifo_full: got %h, expected %h", fifo_full, 1'b0));
    assert (fifo_prog_full == 1'b0) else
      fail_run($sformatf("[ERROR] fifo_prog_full: got %h, expected %h", fifo_prog_full, 1'b0));
    assert (cfg_error == 1'b0) else
      fail_run($sformatf("[ERROR] cfg_error: got %h, expected %h", cfg_error, 1'b0));
    while (fifo_setup) begin
      @(negedge ap_clk);
    end

    check_reserved_level();

    for (int i = 0; i < num_entries; i++) begin
      if (!stim_table[i].stall || stim_table[i].level != cur_level) begin
        drain_router();
      end
      if (stim_table[i].level != cur_level) begin
        write_level(stim_table[i].level);
      end
      if (stim_table[i].stall) begin
        stall_mode <= 1'b1;
        send_response(stim_table[i]);
        @(negedge ap_clk);
        response_in_valid = 1'b0;
        @(negedge ap_clk);
      end else begin
        // Empty FIFO and all ready means the output lands on the fifth edge
        m = mask_at_level(stim_table[i]);
        send_response(stim_table[i]);
        for (int k = 1; k <= 5; k++) begin
          @(negedge ap_clk);
          response_in_valid = 1'b0;
          assert (response_out_valid == ((k == 5) ? m : '0)) else
            fail_run($sformatf("[ERROR] response_out_valid (edge %0d): got %h, expected %h",
                               k, response_out_valid, (k == 5) ? m : '0));
        end
      end
    end

    // Back-to-back burst with no requestor ready
    drain_router();
    hold_ready <= 1'b1;
    repeat (2) @(negedge ap_clk);
    for (int j = 0; j < burst_len; j++) begin
      burst_entry.level  = cur_level;
      burst_entry.data   = resp_data_t'($random(seed));
      burst_entry.cu     = requestor_mask_t'(1 << (j % `RESP_NUM_REQUESTORS));
      burst_entry.bundle = burst_entry.cu;
      burst_entry.lane   = burst_entry.cu;
      burst_entry.stall  = 1'b1;
      send_response(burst_entry);
      @(negedge ap_clk);
    end
    response_in_valid = 1'b0;
    repeat (3) @(negedge ap_clk);
    assert (fifo_prog_full == 1'b1) else
      fail_run($sformatf("[ERROR] fifo_prog_full: got %h, expected %h", fifo_prog_full, 1'b1));
    assert (fifo_full == 1'b1) else
      fail_run($sformatf("[ERROR] fifo_full: got %h, expected %h", fifo_full, 1'b1));
    drain_router();

    if (queues_empty()) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run("Some expected responses never arrived");
    end
  end

endmodule : resp_route_tb

// File: sim.f
+incdir+include
logic/resp_route_pkg.sv
logic/resp_sync_fifo.sv
logic/demux_bus_one_hot.sv
logic/route_level_config.sv
logic/response_arbiter_1_to_n.sv
logic/resp_route_top.sv
tb/resp_route_tb.sv

// File: Bender.yml
package:
  name: resp_route

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/resp_route_pkg.sv
      - logic/resp_sync_fifo.sv
      - logic/demux_bus_one_hot.sv
      - logic/route_level_config.sv
      - logic/response_arbiter_1_to_n.sv
      - logic/resp_route_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/resp_route_tb.sv
